// File: cpu_core.f
logic/core_pkg.sv
logic/exec_bus_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/regfile.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/wb_commit.sv
logic/cpu_core.sv
verif/commit_checker.sv
verif/cpu_core_tb.sv

// File: Makefile
TOP = cpu_core_tb

all: run

build:
	verilator --binary --timing --assert -f cpu_core.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f cpu_core.f --top-module cpu_core

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: verif/cpu_core_tb.sv
// core testbench
`timescale 1ns/1ps

module cpu_core_tb;
  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 32;
  localparam int ADDR_W = $clog2(IMEM_WORDS);
  localparam int NUM_TESTS = 8;
  localparam int MAX_CYCLES = NUM_TESTS * (IMEM_WORDS * 2 + 20);

  logic clock;
  logic reset;
  logic prog_we;
  logic [ADDR_W-1:0] prog_addr;
  logic [31:0] prog_data;
  logic run;
  logic commit_valid;
  logic [63:0] commit_pc;
  logic [31:0] commit_instr;
  logic commit_wen;
  logic [4:0] commit_rd;
  logic [63:0] commit_wdata;
  logic trap;
  logic [7:0] trap_code;
  logic [63:0] cycle_cnt;
  logic [63:0] instr_cnt;
  int errors;
  int checks;
  logic timed_out;

  logic [15:0] lfsr_state;
  logic [31:0] program_words [IMEM_WORDS];
  int prog_len;
  logic [11:0] last_store_off;
  int passed;
  int failed;
  int errors_before;

  cpu_core #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) dut_i (
    .clock_i(clock), .reset_i(reset), .prog_we_i(prog_we), .prog_addr_i(prog_addr),
    .prog_data_i(prog_data), .run_i(run), .commit_valid_o(commit_valid),
    .commit_pc_o(commit_pc), .commit_instr_o(commit_instr), .commit_wen_o(commit_wen),
    .commit_rd_o(commit_rd), .commit_wdata_o(commit_wdata), .trap_o(trap),
    .trap_code_o(trap_code), .cycle_cnt_o(cycle_cnt), .instr_cnt_o(instr_cnt)
  );

  commit_checker #(
    .IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS), .MAX_CYCLES(MAX_CYCLES)
  ) checker_i (
    .clock_i(clock), .reset_i(reset), .run_i(run), .prog_we_i(prog_we),
    .prog_addr_i(prog_addr), .prog_data_i(prog_data), .commit_valid_i(commit_valid),
    .commit_pc_i(commit_pc), .commit_instr_i(commit_instr), .commit_wen_i(commit_wen),
    .commit_rd_i(commit_rd), .commit_wdata_i(commit_wdata), .trap_i(trap),
    .trap_code_i(trap_code), .cycle_cnt_i(cycle_cnt), .instr_cnt_i(instr_cnt),
    .errors_o(errors), .checks_o(checks), .timed_out_o(timed_out)
  );

  always #10 clock = ~clock;

  // galois lfsr, one step per bit
  function automatic logic [31:0] draw_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < nbits; b++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'h13};
  endfunction

  function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [11:0] off);
    return {off, 5'd0, 3'b011, rd, 7'h03};
  endfunction

  function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [11:0] off);
    return {off[11:5], rs2, 5'd0, 3'b011, off[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  // x0 gets picked often on purpose
  function automatic logic [4:0] pick_rd();
    return (draw_bits(3) == 32'd0) ? 5'd0 : 5'(draw_bits(5));
  endfunction

  function automatic logic [31:0] random_alu_word();
    logic [2:0] op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    op = 3'(draw_bits(3));
    rd = pick_rd();
    rs1 = 5'(draw_bits(5));
    rs2 = 5'(draw_bits(5));
    case (op)
      3'd0: return r_type_word(7'h00, 3'b000, rd, rs1, rs2);
      3'd1: return r_type_word(7'h20, 3'b000, rd, rs1, rs2);
      3'd2: return r_type_word(7'h00, 3'b111, rd, rs1, rs2);
      3'd3: return r_type_word(7'h00, 3'b110, rd, rs1, rs2);
      3'd4: return r_type_word(7'h00, 3'b100, rd, rs1, rs2);
      3'd7: return {20'(draw_bits(20)), rd, 7'h37};
      default: return addi_word(rd, rs1, 12'(draw_bits(12)));
    endcase
  endfunction

  function automatic logic [31:0] random_mem_word();
    logic [11:0] off;
    logic is_store;
    is_store = draw_bits(1) != 32'd0;
    // half the accesses reuse the last stored address
    off = (draw_bits(1) != 32'd0) ? last_store_off : 12'(draw_bits(5) * 8);
    if (is_store) begin
      last_store_off = off;
      return store_word(5'(draw_bits(5)), off);
    end
    return load_word(pick_rd(), off);
  endfunction

  // forward only, never past the trap
  function automatic logic [31:0] random_flow_word(input int pos);
    int dest;
    logic [1:0] sel;
    logic [4:0] rs1;
    logic [4:0] rs2;
    dest = pos + 1 + int'(draw_bits(3));
    if (dest > prog_len - 1) begin
      dest = prog_len - 1;
    end
    sel = 2'(draw_bits(2));
    rs1 = 5'(draw_bits(2));
    rs2 = 5'(draw_bits(2));
    case (sel)
      2'd0: return jal_word(pick_rd(), 21'((dest - pos) * 4));
      2'd1: return branch_word(3'b000, rs1, rs2, 13'((dest - pos) * 4));
      default: return branch_word(3'b001, rs1, rs2, 13'((dest - pos) * 4));
    endcase
  endfunction

  task automatic build_program(input int kind);
    logic [2:0] sel;
    if (kind == 0) begin
      // clears every dmem word, later tests load from it
      for (int k = 0; k < DMEM_WORDS; k++) begin
        program_words[k] = store_word(5'd0, 12'(k * 8));
      end
      prog_len = DMEM_WORDS + 2;
      program_words[prog_len - 2] = addi_word(5'd10, 5'd0, 12'h05a);
    end else begin
      prog_len = 24 + int'(draw_bits(4));
      for (int i = 0; i < prog_len - 2; i++) begin
        sel = 3'(draw_bits(3));
        if (kind == 1 || (kind == 2 && sel >= 3'd4) || (kind == 3 && sel >= 3'd4)) begin
          program_words[i] = random_alu_word();
        end else if (kind == 2 || (kind > 3 && sel >= 3'd3 && sel < 3'd5)) begin
          program_words[i] = random_mem_word();
        end else if (kind == 3 || sel >= 3'd5) begin
          program_words[i] = random_flow_word(i);
        end else begin
          program_words[i] = random_alu_word();
        end
      end
      program_words[prog_len - 2] = addi_word(5'd10, 5'(draw_bits(5)), 12'(draw_bits(12)));
    end
    program_words[prog_len - 1] = 32'h0000006b;
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset <= 1'b1;
    run <= 1'b0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
  endtask

  task automatic load_program();
    for (int k = 0; k < prog_len; k++) begin
      @(posedge clock);
      prog_we <= 1'b1;
      prog_addr <= ADDR_W'(k);
      prog_data <= program_words[k];
    end
    @(posedge clock);
    prog_we <= 1'b0;
  endtask

  function automatic string test_label(input int t);
    case (t)
      0: return "idle and dmem clear";
      1: return "alu";
      2: return "store and load";
      3: return "branch and jal";
      default: return "mixed";
    endcase
  endfunction

  always @(posedge clock) begin
    if (timed_out) begin
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    run = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    lfsr_state = 16'd672;
    last_store_off = '0;
    passed = 0;
    failed = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      errors_before = errors;
      apply_reset();
      build_program(t);
      load_program();
      if (t == 0) begin
        repeat (5) @(posedge clock);
      end
      @(posedge clock);
      run <= 1'b1;
      while (trap !== 1'b1) begin
        @(posedge clock);
      end
      // core must stay quiet after the trap
      repeat (3) @(posedge clock);
      run <= 1'b0;
      @(negedge clock);
      if (errors == errors_before) begin
        passed++;
      end else begin
        failed++;
      end
      $display("test %0d (%s): %s, %0d commits, trap code %02h", t, test_label(t),
               (errors == errors_before) ? "ok" : "mismatch", instr_cnt, trap_code);
    end
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             passed, failed, checks, errors);
    if (failed == 0 && errors == 0 && checks > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verif/commit_checker.sv
// commit checker with isa model
`timescale 1ns/1ps

module commit_checker #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 32,
  parameter int MAX_CYCLES = 1000
) (
  input  logic                          clock_i,
  input  logic                          reset_i,
  input  logic                          run_i,
  input  logic                          prog_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr_i,
  input  logic [31:0]                   prog_data_i,
  input  logic                          commit_valid_i,
  input  logic [63:0]                   commit_pc_i,
  input  logic [31:0]                   commit_instr_i,
  input  logic                          commit_wen_i,
  input  logic [4:0]                    commit_rd_i,
  input  logic [63:0]                   commit_wdata_i,
  input  logic                          trap_i,
  input  logic [7:0]                    trap_code_i,
  input  logic [63:0]                   cycle_cnt_i,
  input  logic [63:0]                   instr_cnt_i,
  output int                            errors_o,
  output int                            checks_o,
  output logic                          timed_out_o
);
  localparam int IDX_W = $clog2(IMEM_WORDS);
  localparam int DIDX_W = $clog2(DMEM_WORDS);
  localparam logic [6:0] OP_REG = 7'h33;
  localparam logic [6:0] OP_IMM = 7'h13;
  localparam logic [6:0] OP_LUI = 7'h37;
  localparam logic [6:0] OP_LOAD = 7'h03;
  localparam logic [6:0] OP_STORE = 7'h23;
  localparam logic [6:0] OP_BRANCH = 7'h63;
  localparam logic [6:0] OP_JAL = 7'h6f;
  localparam logic [6:0] OP_TRAP = 7'h6b;

  logic [31:0] prog [IMEM_WORDS];
  logic [63:0] regs [32];
  // dmem is not cleared by reset, so the model keeps it across tests
  logic [63:0] dmem [DMEM_WORDS];
  logic [63:0] pc = '0;
  logic halted = 1'b0;
  logic expect_commit = 1'b0;
  logic timeout_hit = 1'b0;
  int commits = 0;
  int cycles = 0;
  int error_count = 0;
  int check_count = 0;

  assign errors_o = error_count;
  assign checks_o = check_count;
  assign timed_out_o = timeout_hit;

  task automatic check_field(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic retire_model();
    logic [31:0] w;
    logic [4:0] rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic [63:0] next_pc;
    logic wen;
    w = prog[pc[IDX_W+1:2]];
    rd = w[11:7];
    a = regs[w[19:15]];
    b = regs[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    wen = 1'b0;
    wdata = '0;
    next_pc = pc + 64'd4;
    case (w[6:0])
      OP_REG: begin
        wen = 1'b1;
        case (w[14:12])
          3'b000: wdata = (w[31:25] == 7'h20) ? a - b : a + b;
          3'b100: wdata = a ^ b;
          3'b110: wdata = a | b;
          3'b111: wdata = a & b;
          default: wen = 1'b0;
        endcase
      end
      OP_IMM: begin
        wen = 1'b1;
        wdata = a + imm_i;
      end
      OP_LUI: begin
        wen = 1'b1;
        wdata = {{32{w[31]}}, w[31:12], 12'h000};
      end
      OP_LOAD: begin
        wen = 1'b1;
        addr = a + imm_i;
        wdata = dmem[addr[DIDX_W+2:3]];
      end
      OP_STORE: begin
        addr = a + imm_s;
        dmem[addr[DIDX_W+2:3]] = b;
      end
      OP_BRANCH: begin
        // funct3 bit 0 selects bne
        if ((a == b) != w[12]) begin
          next_pc = pc + imm_b;
        end
      end
      OP_JAL: begin
        wen = 1'b1;
        wdata = pc + 64'd4;
        next_pc = pc + imm_j;
      end
      default: begin
      end
    endcase
    check_field("commit_pc_o", pc, commit_pc_i);
    check_field("commit_instr_o", 64'(w), 64'(commit_instr_i));
    check_field("commit_wen_o", 64'(wen), 64'(commit_wen_i));
    check_field("commit_rd_o", wen ? 64'(rd) : 64'd0, 64'(commit_rd_i));
    if (wen) begin
      check_field("commit_wdata_o", wdata, commit_wdata_i);
    end
    commits++;
    if (w[6:0] == OP_TRAP) begin
      halted = 1'b1;
      check_field("trap_code_o", 64'(regs[10][7:0]), 64'(trap_code_i));
      check_field("instr_cnt_o", 64'(commits), instr_cnt_i);
      check_field("cycle_cnt_o", 64'(commits), cycle_cnt_i);
    end
    if (wen && rd != 5'd0) begin
      regs[rd] = wdata;
    end
    pc = next_pc;
  endtask

  always @(posedge clock_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES && !timeout_hit) begin
      $display("timeout: trap never arrived within %0d cycles", MAX_CYCLES);
      timeout_hit <= 1'b1;
    end
    if (prog_we_i && !run_i) begin
      prog[prog_addr_i] = prog_data_i;
    end
    if (!reset_i) begin
      check_field("commit_valid_o", 64'(expect_commit), 64'(commit_valid_i));
      if (commit_valid_i) begin
        retire_model();
      end
      check_field("trap_o", 64'(halted), 64'(trap_i));
    end
    if (reset_i) begin
      for (int r = 0; r < 32; r++) begin
        regs[r] = '0;
      end
      pc = '0;
      halted = 1'b0;
      commits = 0;
      expect_commit = 1'b0;
    end else begin
      // what this edge executes shows up as a commit on the next one
      expect_commit = run_i && !halted;
    end
  end

endmodule

// File: logic/cpu_core.sv
// single-cycle rv64 core
`timescale 1ns/1ps

module cpu_core #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 32
) (
  input  logic                          clock_i,
  input  logic                          reset_i,
  input  logic                          prog_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr_i,
  input  logic [31:0]                   prog_data_i,
  input  logic                          run_i,
  output logic                          commit_valid_o,
  output core_pkg::xlen_t               commit_pc_o,
  output logic [31:0]                   commit_instr_o,
  output logic                          commit_wen_o,
  output core_pkg::reg_idx_t            commit_rd_o,
  output core_pkg::xlen_t               commit_wdata_o,
  output logic                          trap_o,
  output logic [7:0]                    trap_code_o,
  output core_pkg::xlen_t               cycle_cnt_o,
  output core_pkg::xlen_t               instr_cnt_o
);
  import core_pkg::*;

  exec_bus_if bus ();

  xlen_t pc;
  instr_u instr;
  reg_idx_t rs1;
  reg_idx_t rs2;
  xlen_t rs1_data;
  xlen_t rs2_data;
  logic taken;
  xlen_t target;
  xlen_t alu_result;
  xlen_t load_data;
  logic rf_wen;
  reg_idx_t rf_rd;
  xlen_t rf_wdata;
  logic halt;
  logic exec;

  assign exec = run_i && !halt;

  fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (
    .clock_i(clock_i), .reset_i(reset_i), .run_i(run_i), .halt_i(halt),
    .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i),
    .taken_i(taken), .target_i(target), .pc_o(pc), .instr_o(instr)
  );

  decode_stage decode_i (
    .pc_i(pc), .instr_i(instr), .rs1_o(rs1), .rs2_o(rs2),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .bus(bus.decode_mp)
  );

  regfile regfile_i (
    .clock_i(clock_i), .reset_i(reset_i), .rs1_i(rs1), .rs2_i(rs2),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .wen_i(rf_wen), .rd_i(rf_rd), .wdata_i(rf_wdata)
  );

  exec_stage exec_i (
    .bus(bus.exec_mp), .alu_result_o(alu_result), .taken_o(taken), .target_o(target)
  );

  mem_stage #(.DMEM_WORDS(DMEM_WORDS)) mem_i (
    .clock_i(clock_i), .reset_i(reset_i), .exec_i(exec), .wen_i(bus.mem_wen),
    .addr_i(alu_result), .wdata_i(bus.store_data), .load_data_o(load_data)
  );

  // a0 arrives on the first read port during a trap
  wb_commit wb_i (
    .clock_i(clock_i), .reset_i(reset_i), .exec_i(exec), .pc_i(bus.pc),
    .instr_i(bus.instr), .rd_i(bus.rd), .rd_wen_i(bus.rd_wen), .mem_ren_i(bus.mem_ren),
    .alu_result_i(alu_result), .load_data_i(load_data), .a0_i(rs1_data),
    .rd_wen_o(rf_wen), .rd_o(rf_rd), .rd_wdata_o(rf_wdata), .halt_o(halt),
    .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
    .commit_instr_o(commit_instr_o), .commit_wen_o(commit_wen_o),
    .commit_rd_o(commit_rd_o), .commit_wdata_o(commit_wdata_o),
    .trap_o(trap_o), .trap_code_o(trap_code_o),
    .cycle_cnt_o(cycle_cnt_o), .instr_cnt_o(instr_cnt_o)
  );

endmodule

// File: logic/wb_commit.sv
// write-back and commit record
`timescale 1ns/1ps

module wb_commit (
  input  logic               clock_i,
  input  logic               reset_i,
  input  logic               exec_i,
  input  core_pkg::xlen_t    pc_i,
  input  core_pkg::instr_u   instr_i,
  input  core_pkg::reg_idx_t rd_i,
  input  logic               rd_wen_i,
  input  logic               mem_ren_i,
  input  core_pkg::xlen_t    alu_result_i,
  input  core_pkg::xlen_t    load_data_i,
  input  core_pkg::xlen_t    a0_i,
  output logic               rd_wen_o,
  output core_pkg::reg_idx_t rd_o,
  output core_pkg::xlen_t    rd_wdata_o,
  output logic               halt_o,
  output logic               commit_valid_o,
  output core_pkg::xlen_t    commit_pc_o,
  output logic [31:0]        commit_instr_o,
  output logic               commit_wen_o,
  output core_pkg::reg_idx_t commit_rd_o,
  output core_pkg::xlen_t    commit_wdata_o,
  output logic               trap_o,
  output logic [7:0]         trap_code_o,
  output core_pkg::xlen_t    cycle_cnt_o,
  output core_pkg::xlen_t    instr_cnt_o
);
  import core_pkg::*;

  logic is_trap;

  assign rd_wdata_o = mem_ren_i ? load_data_i : alu_result_i;
  assign rd_wen_o = exec_i && rd_wen_i;
  assign rd_o = rd_i;
  assign is_trap = (instr_i.r_fmt.opcode == TRAP_OPCODE);

  always_ff @(posedge clock_i) begin
    if (exec_i) begin
      commit_pc_o <= pc_i;
      commit_instr_o <= instr_i;
      commit_wen_o <= rd_wen_i;
      commit_rd_o <= rd_i;
      commit_wdata_o <= rd_wdata_o;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      commit_valid_o <= 1'b0;
      trap_o <= 1'b0;
      trap_code_o <= '0;
      cycle_cnt_o <= '0;
      instr_cnt_o <= '0;
    end else begin
      commit_valid_o <= exec_i;
      if (exec_i) begin
        cycle_cnt_o <= cycle_cnt_o + 64'd1;
        instr_cnt_o <= instr_cnt_o + 64'd1;
        if (is_trap) begin
          trap_o <= 1'b1;
          trap_code_o <= a0_i[7:0];
        end
      end
    end
  end

  // trap is sticky, so it stops the core
  assign halt_o = trap_o;

  a_no_commit_halted: assert property (@(posedge clock_i) disable iff (reset_i)
    trap_o |=> !commit_valid_o);

endmodule

// File: logic/mem_stage.sv
// data memory
`timescale 1ns/1ps

module mem_stage #(
  parameter int DMEM_WORDS = 32
) (
  input  logic            clock_i,
  input  logic            reset_i,
  input  logic            exec_i,
  input  logic            wen_i,
  input  core_pkg::xlen_t addr_i,
  input  core_pkg::xlen_t wdata_i,
  output core_pkg::xlen_t load_data_o
);
  import core_pkg::*;

  localparam int IDX_W = $clog2(DMEM_WORDS);

  xlen_t dmem [DMEM_WORDS];
  logic [IDX_W-1:0] index;

  // doubleword index, upper address bits ignored
  assign index = addr_i[IDX_W+2:3];

  always_ff @(posedge clock_i) begin
    if (exec_i && wen_i) begin
      dmem[index] <= wdata_i;
    end
  end

  assign load_data_o = dmem[index];

  a_store_aligned: assert property (@(posedge clock_i) disable iff (reset_i)
    (exec_i && wen_i) |-> addr_i[2:0] == 3'b000);

endmodule

// File: logic/exec_stage.sv
// alu and branch resolution
`timescale 1ns/1ps

module exec_stage (
  exec_bus_if.exec_mp     bus,
  output core_pkg::xlen_t alu_result_o,
  output logic            taken_o,
  output core_pkg::xlen_t target_o
);
  import core_pkg::*;

  logic operands_eq;
  logic branch_hit;

  always_comb begin
    case (bus.alu_op)
      ALU_ADD: begin
        alu_result_o = bus.op1 + bus.op2;
      end
      ALU_SUB: begin
        alu_result_o = bus.op1 - bus.op2;
      end
      ALU_AND: begin
        alu_result_o = bus.op1 & bus.op2;
      end
      ALU_OR: begin
        alu_result_o = bus.op1 | bus.op2;
      end
      ALU_XOR: begin
        alu_result_o = bus.op1 ^ bus.op2;
      end
      ALU_PASS_B: begin
        alu_result_o = bus.op2;
      end
      default: begin
        alu_result_o = '0;
      end
    endcase
  end

  assign operands_eq = (bus.op1 == bus.op2);

  // bne flips the sense of the compare
  assign branch_hit = bus.is_branch && (operands_eq ^ bus.branch_ne);

  assign taken_o = bus.is_jal || branch_hit;
  assign target_o = bus.pc + bus.branch_offset;

endmodule

// File: logic/regfile.sv
// integer register file
`timescale 1ns/1ps

module regfile (
  input  logic               clock_i,
  input  logic               reset_i,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  output core_pkg::xlen_t    rs1_data_o,
  output core_pkg::xlen_t    rs2_data_o,
  input  logic               wen_i,
  input  core_pkg::reg_idx_t rd_i,
  input  core_pkg::xlen_t    wdata_i
);
  import core_pkg::*;

  xlen_t regs [32];

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

  // x0 survives a write aimed at it
  a_x0_zero: assert property (@(posedge clock_i) disable iff (reset_i)
    (wen_i && rd_i == '0) |=> regs[0] == '0);

endmodule

// File: logic/decode_stage.sv
// instruction decode
`timescale 1ns/1ps

module decode_stage (
  input  core_pkg::xlen_t    pc_i,
  input  core_pkg::instr_u   instr_i,
  output core_pkg::reg_idx_t rs1_o,
  output core_pkg::reg_idx_t rs2_o,
  input  core_pkg::xlen_t    rs1_data_i,
  input  core_pkg::xlen_t    rs2_data_i,
  exec_bus_if.decode_mp      bus
);
  import core_pkg::*;

  logic [6:0] opcode;
  xlen_t i_imm;
  xlen_t s_imm;
  xlen_t b_imm;
  xlen_t u_imm;
  xlen_t j_imm;

  function automatic alu_op_t funct_to_alu(input logic [2:0] funct3, input logic sub);
    case (funct3)
      3'b000: return sub ? ALU_SUB : ALU_ADD;
      3'b100: return ALU_XOR;
      3'b110: return ALU_OR;
      3'b111: return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign opcode = instr_i.r_fmt.opcode;

  assign i_imm = {{52{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
  assign s_imm = {{52{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
  assign b_imm = {{51{instr_i.b_fmt.imm12}}, instr_i.b_fmt.imm12, instr_i.b_fmt.imm11,
                  instr_i.b_fmt.imm10_5, instr_i.b_fmt.imm4_1, 1'b0};
  assign u_imm = {{32{instr_i.u_fmt.imm31_12[19]}}, instr_i.u_fmt.imm31_12, 12'h000};
  assign j_imm = {{43{instr_i.j_fmt.imm20}}, instr_i.j_fmt.imm20, instr_i.j_fmt.imm19_12,
                  instr_i.j_fmt.imm11, instr_i.j_fmt.imm10_1, 1'b0};

  // trap reads a0 on the first port for its code
  assign rs1_o = (opcode == TRAP_OPCODE) ? reg_idx_t'(10) : instr_i.r_fmt.rs1;
  assign rs2_o = instr_i.r_fmt.rs2;

  assign bus.pc = pc_i;
  assign bus.instr = instr_i;
  assign bus.store_data = rs2_data_i;

  always_comb begin
    bus.alu_op = ALU_ADD;
    bus.op1 = rs1_data_i;
    bus.op2 = rs2_data_i;
    bus.rd = '0;
    bus.rd_wen = 1'b0;
    bus.mem_ren = 1'b0;
    bus.mem_wen = 1'b0;
    bus.is_branch = 1'b0;
    bus.branch_ne = 1'b0;
    bus.is_jal = 1'b0;
    bus.branch_offset = b_imm;
    case (opcode)
      OPC_OP: begin
        bus.alu_op = funct_to_alu(instr_i.r_fmt.funct3, instr_i.r_fmt.funct7[5]);
        bus.rd = instr_i.r_fmt.rd;
        bus.rd_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        bus.alu_op = funct_to_alu(instr_i.i_fmt.funct3, 1'b0);
        bus.op2 = i_imm;
        bus.rd = instr_i.i_fmt.rd;
        bus.rd_wen = 1'b1;
      end
      OPC_LUI: begin
        bus.alu_op = ALU_PASS_B;
        bus.op2 = u_imm;
        bus.rd = instr_i.u_fmt.rd;
        bus.rd_wen = 1'b1;
      end
      OPC_LOAD: begin
        bus.op2 = i_imm;
        bus.rd = instr_i.i_fmt.rd;
        bus.rd_wen = 1'b1;
        bus.mem_ren = 1'b1;
      end
      OPC_STORE: begin
        bus.op2 = s_imm;
        bus.mem_wen = 1'b1;
      end
      OPC_BRANCH: begin
        bus.is_branch = 1'b1;
        bus.branch_ne = instr_i.b_fmt.funct3[0];
      end
      OPC_JAL: begin
        // link value comes out of the alu as pc + 4
        bus.op1 = pc_i;
        bus.op2 = 64'd4;
        bus.rd = instr_i.j_fmt.rd;
        bus.rd_wen = 1'b1;
        bus.is_jal = 1'b1;
        bus.branch_offset = j_imm;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: logic/fetch_stage.sv
// instruction fetch
`timescale 1ns/1ps

module fetch_stage #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          clock_i,
  input  logic                          reset_i,
  input  logic                          run_i,
  input  logic                          halt_i,
  input  logic                          prog_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr_i,
  input  logic [31:0]                   prog_data_i,
  input  logic                          taken_i,
  input  core_pkg::xlen_t               target_i,
  output core_pkg::xlen_t               pc_o,
  output core_pkg::instr_u              instr_o
);
  import core_pkg::*;

  localparam int IDX_W = $clog2(IMEM_WORDS);

  logic [31:0] imem [IMEM_WORDS];

  // loading only allowed while idle
  always_ff @(posedge clock_i) begin
    if (prog_we_i && !run_i) begin
      imem[prog_addr_i] <= prog_data_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pc_o <= PC_START;
    end else if (run_i && !halt_i) begin
      pc_o <= taken_i ? target_i : pc_o + 64'd4;
    end
  end

  // word index wraps around the ram
  assign instr_o = imem[pc_o[IDX_W+1:2]];

  a_pc_aligned: assert property (@(posedge clock_i) disable iff (reset_i)
    pc_o[1:0] == 2'b00);

endmodule

// File: logic/exec_bus_if.sv
// decode to execute bus
`timescale 1ns/1ps

interface exec_bus_if;
  import core_pkg::*;

  xlen_t pc;
  instr_u instr;
  alu_op_t alu_op;
  xlen_t op1;
  xlen_t op2;
  xlen_t store_data;
  reg_idx_t rd;
  logic rd_wen;
  logic mem_ren;
  logic mem_wen;
  logic is_branch;
  logic branch_ne;
  logic is_jal;
  xlen_t branch_offset;

  modport decode_mp (
    output pc, instr, alu_op, op1, op2, store_data, rd,
    output rd_wen, mem_ren, mem_wen, is_branch, branch_ne, is_jal, branch_offset
  );

  modport exec_mp (
    input pc, instr, alu_op, op1, op2, store_data, rd,
    input rd_wen, mem_ren, mem_wen, is_branch, branch_ne, is_jal, branch_offset
  );

endinterface

// File: logic/core_pkg.sv
// core shared definitions
package core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [4:0] reg_idx_t;

  localparam xlen_t PC_START = 64'h0;
  localparam logic [6:0] TRAP_OPCODE = 7'h6b;

  // major opcodes
  localparam logic [6:0] OPC_OP = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI = 7'h37;
  localparam logic [6:0] OPC_LOAD = 7'h03;
  localparam logic [6:0] OPC_STORE = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL = 7'h6f;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t rs2;
    reg_idx_t rs1;
    logic [2:0] funct3;
    reg_idx_t rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t rs1;
    logic [2:0] funct3;
    reg_idx_t rd;
    logic [6:0] opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t rs2;
    reg_idx_t rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic imm12;
    logic [5:0] imm10_5;
    reg_idx_t rs2;
    reg_idx_t rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    reg_idx_t rd;
    logic [6:0] opcode;
  } u_fmt_t;

  typedef struct packed {
    logic imm20;
    logic [9:0] imm10_1;
    logic imm11;
    logic [7:0] imm19_12;
    reg_idx_t rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, six ways to read it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

endpackage
